// File: flist.f
hdl/io_bus_pkg.sv
hdl/io_decoder.sv
hdl/interval_timer.sv
hdl/irq_controller.sv
hdl/system_control_regs.sv
hdl/io_subsystem.sv
tb/io_subsystem_tb.sv

// File: hdl/interval_timer.sv
`timescale 1ns/1ps

module interval_timer
    import io_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sel,
    input  io_req_t io_req,
    output io_rsp_t rsp,
    output logic    timer_intr
);

    logic [15:0] reload;
    logic [15:0] count;
    logic [7:0]  prescale;
    logic        running;
    logic        cycle_en;
    logic        wr_hit;
    logic        tick;

    assign cycle_en = sel & ~rsp.ack;            // First cycle of the access
    assign wr_hit   = cycle_en & io_req.wr_en;
    assign tick     = running && (prescale == TIMER_PRESCALE - 8'd1);

    // Reload value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reload <= 16'h0000;
        end else if (wr_hit) begin
            reload <= io_req.wdata;
        end
    end

    // Prescaler, restarts on every write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale <= 8'd0;
        end else if (wr_hit || !running || tick) begin
            prescale <= 8'd0;
        end else begin
            prescale <= prescale + 8'd1;
        end
    end

    // Down-counter and sticky interrupt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count      <= 16'h0000;
            running    <= 1'b0;
            timer_intr <= 1'b0;
        end else if (wr_hit) begin
            count      <= io_req.wdata;
            running    <= (io_req.wdata != 16'h0000); // Zero stops
            timer_intr <= 1'b0;
        end else if (tick) begin
            if (count == 16'h0001) begin
                count      <= reload;
                timer_intr <= 1'b1;
            end else begin
                count <= count - 16'h0001;
            end
        end
    end

    // Bus response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.ack   <= cycle_en;
            rsp.rdata <= (cycle_en && !io_req.wr_en) ? count : 16'h0000;
        end
    end

endmodule

// File: hdl/io_bus_pkg.sv
package io_bus_pkg;

    // Request from the CPU data master, held until ack
    typedef struct packed {
        logic        io;        // I/O space access
        logic        access;
        logic        wr_en;
        logic [1:0]  bytesel;
        logic [15:1] addr;      // Word address
        logic [15:0] wdata;
    } io_req_t;

    // Target response, rdata must be zero while ack is low
    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;
    } io_rsp_t;

    // Register word addresses, byte address in the comment
    localparam logic [15:1] ADDR_LEDS      = 15'h7fff; // FFFE
    localparam logic [15:1] ADDR_BIOS_CTRL = 15'h7ff6; // FFEC
    localparam logic [15:1] ADDR_TIMER     = 15'h7ff7; // FFEE
    localparam logic [15:1] ADDR_IRQ_MASK  = 15'h7ffa; // FFF4
    localparam logic [15:1] ADDR_IRQ_CTRL  = 15'h7ffb; // FFF6

    // Interrupt controller
    localparam int          NUM_IRQ         = 8;
    localparam logic [7:0]  IRQ_VECTOR_BASE = 8'h08;

    // Clocks per timer tick
    localparam logic [7:0]  TIMER_PRESCALE  = 8'd4;

    localparam int          NUM_LEDS        = 8;

endpackage

// File: hdl/io_decoder.sv
`timescale 1ns/1ps

module io_decoder
    import io_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  io_req_t io_req,
    output logic    timer_sel,
    output logic    irq_sel,
    output logic    sysctl_sel,
    output logic    default_sel,
    output io_rsp_t default_rsp
);

    logic io_access;
    logic hit_timer;
    logic hit_irq;
    logic hit_sysctl;

    assign io_access = io_req.io & io_req.access;

    // Address match only, qualified with the access below
    always_comb begin
        hit_timer  = (io_req.addr == ADDR_TIMER);
        // Mask and control share one window, addr[1] picks the register
        hit_irq    = (io_req.addr[15:2] == ADDR_IRQ_MASK[15:2]);
        hit_sysctl = (io_req.addr == ADDR_BIOS_CTRL) ||
                     (io_req.addr == ADDR_LEDS);
    end

    always_comb begin
        timer_sel   = 1'b0;
        irq_sel     = 1'b0;
        sysctl_sel  = 1'b0;
        default_sel = 1'b0;
        if (io_access) begin
            if (hit_timer) begin
                timer_sel = 1'b1;
            end else if (hit_irq) begin
                irq_sel = 1'b1;
            end else if (hit_sysctl) begin
                sysctl_sel = 1'b1;
            end else begin
                default_sel = 1'b1; // Unclaimed, incl. UART/SPI/VGA/PS2
            end
        end
    end

    // Default responder, acks with zero data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            default_rsp <= '0;
        end else begin
            default_rsp.ack   <= default_sel & ~default_rsp.ack; // One ack per access
            default_rsp.rdata <= 16'h0000;
        end
    end

endmodule

// File: hdl/io_subsystem.sv
`timescale 1ns/1ps

module io_subsystem
    import io_bus_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  io_req_t             io_req,
    output io_rsp_t             io_rsp,
    input  logic [6:0]          ext_intr,
    output logic                intr,
    output logic                nmi,
    output logic [7:0]          irq_vector,
    output logic                bios_enabled,
    output logic [NUM_LEDS-1:0] leds
);

    logic    timer_sel;
    logic    irq_sel;
    logic    sysctl_sel;
    logic    default_sel;

    io_rsp_t timer_rsp;
    io_rsp_t irq_rsp;
    io_rsp_t sysctl_rsp;
    io_rsp_t default_rsp;

    logic    timer_intr;

    io_decoder io_decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .io_req      (io_req),
        .timer_sel   (timer_sel),
        .irq_sel     (irq_sel),
        .sysctl_sel  (sysctl_sel),
        .default_sel (default_sel),
        .default_rsp (default_rsp)
    );

    interval_timer interval_timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (timer_sel),
        .io_req     (io_req),
        .rsp        (timer_rsp),
        .timer_intr (timer_intr)
    );

    irq_controller irq_controller_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (irq_sel),
        .io_req     (io_req),
        .rsp        (irq_rsp),
        .intr_in    ({ext_intr, timer_intr}), // Timer is line 0
        .intr       (intr),
        .nmi        (nmi),
        .irq_vector (irq_vector)
    );

    system_control_regs system_control_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sel          (sysctl_sel),
        .io_req       (io_req),
        .rsp          (sysctl_rsp),
        .bios_enabled (bios_enabled),
        .leds         (leds)
    );

    // Idle targets drive zeros, so a plain OR merges them
    assign io_rsp = timer_rsp | irq_rsp | sysctl_rsp | default_rsp;

endmodule

// File: hdl/irq_controller.sv
`timescale 1ns/1ps

module irq_controller
    import io_bus_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sel,
    input  io_req_t            io_req,
    output io_rsp_t            rsp,
    input  logic [NUM_IRQ-1:0] intr_in,
    output logic               intr,
    output logic               nmi,
    output logic [7:0]         irq_vector
);

    logic [NUM_IRQ-1:0] mask;
    logic [NUM_IRQ-1:0] pending;
    logic               cycle_en;
    logic               ctrl_reg;
    logic [15:0]        rd_val;

    assign cycle_en = sel & ~rsp.ack;
    assign ctrl_reg = io_req.addr[1];    // 0 mask at FFF4, 1 control at FFF6

    // Mask and nmi registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask <= '1;                  // Everything masked
            nmi  <= 1'b0;
        end else if (cycle_en && io_req.wr_en && io_req.bytesel[0]) begin
            if (ctrl_reg) begin
                nmi <= io_req.wdata[0];
            end else begin
                mask <= io_req.wdata[NUM_IRQ-1:0];
            end
        end
    end

    assign pending = intr_in & ~mask;
    assign intr    = |pending;

    // Lowest active line wins
    always_comb begin
        irq_vector = 8'h00;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_vector = IRQ_VECTOR_BASE + 8'(i);
            end
        end
    end

    always_comb begin
        if (ctrl_reg) begin
            rd_val = 16'({nmi, intr_in}); // Raw lines, nmi above them
        end else begin
            rd_val = 16'(mask);
        end
    end

    // Bus response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.ack   <= cycle_en;
            rsp.rdata <= (cycle_en && !io_req.wr_en) ? rd_val : 16'h0000;
        end
    end

endmodule

// File: hdl/system_control_regs.sv
`timescale 1ns/1ps

module system_control_regs
    import io_bus_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sel,
    input  io_req_t             io_req,
    output io_rsp_t             rsp,
    output logic                bios_enabled,
    output logic [NUM_LEDS-1:0] leds
);

    logic        cycle_en;
    logic        low_wr;
    logic        is_bios;
    logic [15:0] rd_val;

    assign cycle_en = sel & ~rsp.ack;
    assign low_wr   = cycle_en & io_req.wr_en & io_req.bytesel[0];
    assign is_bios  = (io_req.addr == ADDR_BIOS_CTRL); // Else the LED word

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bios_enabled <= 1'b1;         // Boot from BIOS ROM
            leds         <= '0;
        end else if (low_wr) begin
            if (is_bios) begin
                bios_enabled <= io_req.wdata[0];
            end else begin
                leds <= io_req.wdata[NUM_LEDS-1:0];
            end
        end
    end

    assign rd_val = is_bios ? 16'(bios_enabled) : 16'(leds);

    // Bus response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.ack   <= cycle_en;
            rsp.rdata <= (cycle_en && !io_req.wr_en) ? rd_val : 16'h0000;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the I/O subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module io_subsystem_tb -f flist.f -o io_subsystem_sim

# A $fatal in the testbench gives a failing exit status
./obj_dir/io_subsystem_sim

// File: tb/io_subsystem_tb.sv
`timescale 1ns/1ps

module io_subsystem_tb
    import io_bus_pkg::*;
();

    localparam int ACK_TIMEOUT = 20;        // Cycles per bus access
    localparam int POLL_LIMIT  = 30;        // Timer reads before giving up

    // Byte addresses as seen by the CPU
    localparam logic [15:0] BYTE_LEDS     = 16'hfffe;
    localparam logic [15:0] BYTE_BIOS     = 16'hffec;
    localparam logic [15:0] BYTE_TIMER    = 16'hffee;
    localparam logic [15:0] BYTE_IRQ_MASK = 16'hfff4;
    localparam logic [15:0] BYTE_IRQ_CTRL = 16'hfff6;

    localparam logic WR = 1'b1;
    localparam logic RD = 1'b0;

    typedef struct packed {
        logic        wr;
        logic [15:0] byte_addr;
        logic [1:0]  bytesel;
        logic [15:0] data;
        logic [6:0]  ext;
        logic [15:0] exp_rdata;             // Reads only
        logic [7:0]  exp_vec;               // Zero means intr low
    } step_t;

    logic                clk;
    logic                rst_n;
    io_req_t             io_req;
    io_rsp_t             io_rsp;
    logic [6:0]          ext_intr;
    logic                intr;
    logic                nmi;
    logic [7:0]          irq_vector;
    logic                bios_enabled;
    logic [NUM_LEDS-1:0] leds;

    step_t       steps[$];
    step_t       cur;
    logic [31:0] lcg_state = 32'd4898;
    logic [7:0]  model_leds;
    logic        model_bios;
    logic        model_nmi;

    io_subsystem io_subsystem_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_req       (io_req),
        .io_rsp       (io_rsp),
        .ext_intr     (ext_intr),
        .intr         (intr),
        .nmi          (nmi),
        .irq_vector   (irq_vector),
        .bios_enabled (bios_enabled),
        .leds         (leds)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic is_register(input logic [15:0] a);
        return (a == BYTE_LEDS) || (a == BYTE_BIOS) || (a == BYTE_TIMER) ||
               (a == BYTE_IRQ_MASK) || (a == BYTE_IRQ_CTRL);
    endfunction

    function automatic logic [15:0] random_unclaimed();
        logic [15:0] a;
        do begin
            a = next_random() & 16'hfffe;   // Word aligned
        end while (is_register(a));
        return a;
    endfunction

    task automatic abort_run(input string reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            abort_run("Value mismatch");
        end
    endtask

    // One access from falling edge to falling edge
    task automatic bus_access(input logic wr, input logic [15:0] byte_addr,
                              input logic [1:0] bytesel, input logic [15:0] wdata,
                              output logic [15:0] rdata);
        int cycles;
        io_req.io      = 1'b1;
        io_req.access  = 1'b1;
        io_req.wr_en   = wr;
        io_req.bytesel = bytesel;
        io_req.addr    = byte_addr[15:1];
        io_req.wdata   = wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!io_rsp.ack && cycles < ACK_TIMEOUT);
        if (!io_rsp.ack) begin
            $display("No ack within %0d cycles for address %h", ACK_TIMEOUT, byte_addr);
            abort_run("Bus access timed out");
        end
        check_value("ack latency", cycles, 32'd1);
        rdata = io_rsp.rdata;
        @(negedge clk);                     // Request still held in the cycle after ack
        check_value("second ack", 32'(io_rsp.ack), 32'd0);
        check_value("rdata without ack", 32'(io_rsp.rdata), 32'd0);
        io_req = '0;
        @(negedge clk);
        check_value("ack after release", 32'(io_rsp.ack), 32'd0);
    endtask

    task automatic check_outputs(input logic [7:0] exp_vec);
        check_value("leds", 32'(leds), 32'(model_leds));
        check_value("bios_enabled", 32'(bios_enabled), 32'(model_bios));
        check_value("nmi", 32'(nmi), 32'(model_nmi));
        check_value("intr", 32'(intr), 32'(exp_vec != 8'h00));
        check_value("irq_vector", 32'(irq_vector), 32'(exp_vec));
    endtask

    task automatic add_step(input logic wr, input logic [15:0] byte_addr,
                            input logic [1:0] bytesel, input logic [15:0] data,
                            input logic [6:0] ext, input logic [15:0] exp_rdata,
                            input logic [7:0] exp_vec);
        step_t s;
        s = {wr, byte_addr, bytesel, data, ext, exp_rdata, exp_vec};
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [15:0] led_a;
        logic [15:0] led_b;
        led_a = next_random();
        led_b = next_random();
        // Control registers with all lines still masked
        add_step(RD, BYTE_LEDS, 2'b11, 16'h0000, 7'h00, 16'h0000, 8'h00);
        add_step(RD, BYTE_BIOS, 2'b11, 16'h0000, 7'h00, 16'h0001, 8'h00);
        add_step(WR, BYTE_LEDS, 2'b01, led_a,    7'h00, 16'h0000, 8'h00);
        add_step(RD, BYTE_LEDS, 2'b11, 16'h0000, 7'h00, {8'h00, led_a[7:0]}, 8'h00);
        add_step(WR, BYTE_LEDS, 2'b11, led_b,    7'h00, 16'h0000, 8'h00);
        add_step(RD, BYTE_LEDS, 2'b11, 16'h0000, 7'h00, {8'h00, led_b[7:0]}, 8'h00);
        add_step(WR, BYTE_LEDS, 2'b00, ~led_b,   7'h00, 16'h0000, 8'h00);
        add_step(WR, BYTE_LEDS, 2'b10, ~led_b,   7'h00, 16'h0000, 8'h00);
        add_step(RD, BYTE_LEDS, 2'b11, 16'h0000, 7'h00, {8'h00, led_b[7:0]}, 8'h00);
        add_step(WR, BYTE_BIOS, 2'b01, 16'h0000, 7'h00, 16'h0000, 8'h00);
        add_step(RD, BYTE_BIOS, 2'b11, 16'h0000, 7'h00, 16'h0000, 8'h00);
        add_step(WR, BYTE_BIOS, 2'b00, 16'h0001, 7'h00, 16'h0000, 8'h00);
        add_step(RD, BYTE_BIOS, 2'b11, 16'h0000, 7'h00, 16'h0000, 8'h00);
        // Unclaimed addresses next to the irq window and elsewhere
        add_step(RD, 16'hfff0, 2'b11, 16'h0000, 7'h00, 16'h0000, 8'h00);
        add_step(RD, 16'hfff8, 2'b11, 16'h0000, 7'h00, 16'h0000, 8'h00);
        for (int k = 0; k < 4; k++) begin
            add_step(RD, random_unclaimed(), 2'b11, 16'h0000, 7'h00, 16'h0000, 8'h00);
        end
        add_step(WR, random_unclaimed(), 2'b11, 16'hffff, 7'h00, 16'h0000, 8'h00);
        // Interrupts where ext bit k is line k+1
        add_step(RD, BYTE_IRQ_MASK, 2'b11, 16'h0000, 7'b0000000, 16'h00ff, 8'h00);
        add_step(WR, BYTE_IRQ_MASK, 2'b01, 16'h00f0, 7'b0000010, 16'h0000, 8'h0a);
        add_step(RD, BYTE_IRQ_CTRL, 2'b11, 16'h0000, 7'b1010110, 16'h00ac, 8'h0a);
        add_step(WR, BYTE_IRQ_MASK, 2'b01, 16'h0003, 7'b1010000, 16'h0000, 8'h0d);
        add_step(RD, BYTE_IRQ_CTRL, 2'b11, 16'h0000, 7'b1111111, 16'h00fe, 8'h0a);
        add_step(WR, BYTE_IRQ_CTRL, 2'b01, 16'h0001, 7'b0000001, 16'h0000, 8'h00);
        add_step(RD, BYTE_IRQ_CTRL, 2'b11, 16'h0000, 7'b0000001, 16'h0102, 8'h00);
        add_step(WR, BYTE_IRQ_MASK, 2'b01, 16'h0000, 7'b0000001, 16'h0000, 8'h09);
        add_step(WR, BYTE_IRQ_MASK, 2'b00, 16'h00ff, 7'b1000000, 16'h0000, 8'h0f);
        add_step(RD, BYTE_IRQ_MASK, 2'b11, 16'h0000, 7'b1000000, 16'h0000, 8'h0f);
        add_step(RD, BYTE_IRQ_CTRL, 2'b11, 16'h0000, 7'b1000000, 16'h0180, 8'h0f);
        add_step(WR, BYTE_IRQ_CTRL, 2'b01, 16'h0000, 7'b0000000, 16'h0000, 8'h00);
        add_step(WR, BYTE_IRQ_MASK, 2'b01, 16'h00fe, 7'b0000000, 16'h0000, 8'h00);
        add_step(RD, BYTE_IRQ_MASK, 2'b11, 16'h0000, 7'b0000000, 16'h00fe, 8'h00);
    endtask

    task automatic apply_table();
        logic [15:0] rd;
        for (int i = 0; i < steps.size(); i++) begin
            cur      = steps[i];
            ext_intr = cur.ext;
            bus_access(cur.wr, cur.byte_addr, cur.bytesel, cur.data, rd);
            if (cur.wr && cur.bytesel[0]) begin
                case (cur.byte_addr)
                    BYTE_LEDS:     model_leds = cur.data[7:0];
                    BYTE_BIOS:     model_bios = cur.data[0];
                    BYTE_IRQ_CTRL: model_nmi  = cur.data[0];
                    default:       ;
                endcase
            end
            if (!cur.wr) begin
                check_value("read data", 32'(rd), 32'(cur.exp_rdata));
            end
            check_outputs(cur.exp_vec);
        end
    endtask

    // Only line 0 is unmasked when this runs
    task automatic run_timer();
        logic [15:0] rd;
        int          polls;
        ext_intr = 7'h00;
        bus_access(WR, BYTE_TIMER, 2'b11, 16'd3, rd);
        polls = 0;
        while (!intr && polls < POLL_LIMIT) begin
            bus_access(RD, BYTE_TIMER, 2'b11, 16'h0000, rd);
            check_value("timer count above reload", 32'(rd > 16'd3), 32'd0);
            polls++;
        end
        if (!intr) begin
            abort_run("Timer interrupt did not arrive within the poll limit");
        end
        check_value("timer irq_vector", 32'(irq_vector), 32'h08);
        repeat (3) begin
            bus_access(RD, BYTE_TIMER, 2'b11, 16'h0000, rd);
            check_value("timer count above reload", 32'(rd > 16'd3), 32'd0);
            check_value("sticky timer intr", 32'(intr), 32'd1);
        end
        bus_access(WR, BYTE_TIMER, 2'b11, 16'd3, rd);
        check_value("intr after timer write", 32'(intr), 32'd0);
        bus_access(WR, BYTE_TIMER, 2'b11, 16'd0, rd);     // Stop
        repeat (6) begin
            bus_access(RD, BYTE_TIMER, 2'b11, 16'h0000, rd);
            check_value("stopped timer count", 32'(rd), 32'd0);
            check_value("stopped timer intr", 32'(intr), 32'd0);
        end
    endtask

    initial begin
        io_req     = '0;
        ext_intr   = 7'h00;
        rst_n      = 1'b0;
        model_leds = 8'h00;
        model_bios = 1'b1;
        model_nmi  = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("ack after reset", 32'(io_rsp.ack), 32'd0);
        check_value("rdata after reset", 32'(io_rsp.rdata), 32'd0);
        check_outputs(8'h00);
        apply_table();
        run_timer();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
